//--- threshold_servo.f
servo_pkg.sv
trig_bus_pkg.sv
loop_timer.sv
servo_fsm.sv
trigger_bus_master.sv
threshold_bank.sv
reg_read_port.sv
threshold_servo_top.sv
threshold_servo_properties.sv
threshold_servo_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the threshold servo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module threshold_servo_tb -f threshold_servo.f

# A failed assertion stops the simulation early, the search below decides
output=$(./obj_dir/Vthreshold_servo_tb || true)
echo "$output"

if echo "$output" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1

//--- threshold_servo_tb.sv
module threshold_servo_tb;

    import servo_pkg::*;
    import trig_bus_pkg::*;

    localparam int NBEAMS = 2;
    localparam int TARGET = 100;
    localparam int KP     = 1;
    localparam int MARGIN = 10;
    localparam int BOOT   = 31;
    localparam int RESET_THRESH = 19000;              // Every threshold after reset
    localparam int POLLS  = 3;                        // Done reported on the third poll
    localparam int OPS    = 2 + POLLS + 3 * NBEAMS;   // Trigger operations per round
    localparam int LIMIT  = 400;                      // Cycles before a wait gives up

    logic              wb_clk_i = 1'b0;
    logic              reset_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [ADDR_W-1:0] wb_adr_i, trig_adr_o;
    logic [DATA_W-1:0] wb_dat_i, wb_dat_o, trig_dat_o;
    logic              trig_cyc_o, trig_stb_o, trig_we_o;
    logic              trig_ack_i = 1'b0;
    logic [DATA_W-1:0] trig_dat_i = '0;

    logic [ADDR_W-1:0] log_adr [$];   // Every acked trigger request
    logic              log_we [$];
    logic [DATA_W-1:0] log_dat [$];
    thresh_t           exp_thresh [NBEAMS];
    int                hold_cnt = 0, poll_cnt = 0, round_num = 0, stalls = 0;
    int                errors = 0, total = 0, failed = 0, test_num = 1, waited;
    bit                timed_out = 1'b0;

    initial begin
        forever #20 wb_clk_i = ~wb_clk_i;
    end

    threshold_servo_top #(.NBEAMS(NBEAMS), .STARTING_TARGET(TARGET), .STARTING_KP(KP),
        .COUNT_MARGIN(MARGIN), .BOOT_DELAY_CLOCKS(BOOT)) threshold_servo_top_i (.*);

    function automatic int count_for(input int rnd, input int beam);
        if (beam == 0)
            return 150;
        return (rnd == 0) ? 50 : 105;                 // Beam 1 moves into the band later
    endfunction

    function automatic thresh_t next_thresh(input thresh_t old_thresh, input int count);
        if (count > TARGET + MARGIN)
            return old_thresh + thresh_t'(KP);        // Rate too high
        if (count < TARGET - MARGIN)
            return old_thresh - thresh_t'(KP);
        return old_thresh;
    endfunction

    //////////////////////////////////////////////////
    // Trigger responder model
    //////////////////////////////////////////////////
    always @(posedge wb_clk_i) begin
        if (reset_i || trig_ack_i) begin
            trig_ack_i <= 1'b0;                       // Ack lasts one cycle
        end else if (trig_cyc_o && trig_stb_o) begin
            if (hold_cnt > 0) begin
                hold_cnt = hold_cnt - 1;              // Withhold ack
                stalls = stalls + 1;
            end else begin
                trig_ack_i <= 1'b1;
                trig_dat_i <= '0;
                log_adr.push_back(trig_adr_o);
                log_we.push_back(trig_we_o);
                log_dat.push_back(trig_dat_o);
                if (trig_we_o && trig_adr_o == CMD_ADDR && trig_dat_o == CMD_UPDATE) begin
                    round_num = round_num + 1;
                end else if (!trig_we_o && trig_adr_o == CMD_ADDR) begin
                    poll_cnt = (poll_cnt + 1) % POLLS;
                    trig_dat_i <= (poll_cnt == 0) ? 32'd1 : 32'd0;  // Done flag in bit 0
                end else if (!trig_we_o) begin
                    trig_dat_i <= 32'(count_for(round_num, int'(trig_adr_o - COUNT_BASE)));
                end
                hold_cnt = int'($urandom_range(3, 0));
            end
        end
    end

    task automatic compare(input string name, input logic [DATA_W-1:0] expected,
                           input logic [DATA_W-1:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH time %0t %s expected %0d actual %0d", $time, name, expected,
                     actual);
            errors = errors + 1;
        end
    endtask

    task automatic require(input bit ok, input string what);
        assert (ok) else begin
            $display("Check failed at time %0t: %s", $time, what);
            errors = errors + 1;
        end
    endtask

    task automatic report_test(input string name);
        if (errors != 0)
            failed = failed + 1;
        $display("Test %0d %s: %0d errors", test_num, name, errors);
        total = total + errors;
        errors = 0;
        test_num = test_num + 1;
    endtask

    task automatic wait_log(input int n);
        int cycles;
        cycles = 0;
        while (log_adr.size() < n && cycles < LIMIT) begin
            @(negedge wb_clk_i);
            cycles = cycles + 1;
        end
        if (log_adr.size() < n) begin
            $display("Timeout: only %0d of %0d trigger requests answered", log_adr.size(), n);
            timed_out = 1'b1;
        end
    endtask

    // One upstream read with its data and ack delay checked
    task automatic read_expect(input string name, input logic [ADDR_W-1:0] adr,
                               input logic [DATA_W-1:0] expected);
        int cycles;
        cycles = 0;
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_adr_i <= adr;
        do begin
            @(negedge wb_clk_i);
            cycles = cycles + 1;
        end while (wb_ack_o !== 1'b1 && cycles < 8);
        if (wb_ack_o !== 1'b1) begin
            $display("Timeout: no wb_ack_o for the read of address %0h", adr);
            timed_out = 1'b1;
        end else begin
            compare("wb_ack_o delay", 32'd3, 32'(cycles));   // Sampling edge plus two
            compare(name, expected, wb_dat_o);
        end
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    task automatic match_request(input int idx, input logic [ADDR_W-1:0] adr,
                                 input logic we, input logic [DATA_W-1:0] dat);
        compare($sformatf("trig_adr_o of request %0d", idx), 32'(adr), 32'(log_adr[idx]));
        compare($sformatf("trig_we_o of request %0d", idx), 32'(we), 32'(log_we[idx]));
        if (we)
            compare($sformatf("trig_dat_o of request %0d", idx), dat, log_dat[idx]);
    endtask

    // Start, polls, then one count read per beam
    task automatic check_reads(input int rnd);
        int base;
        base = rnd * OPS;
        match_request(base, CMD_ADDR, 1'b1, CMD_START);
        for (int p = 1; p <= POLLS; p++)
            match_request(base + p, CMD_ADDR, 1'b0, '0);
        for (int b = 0; b < NBEAMS; b++)
            match_request(base + POLLS + 1 + b, COUNT_BASE + ADDR_W'(b), 1'b0, '0);
    endtask

    // Thresholds, enables, then the update command
    task automatic check_writes(input int rnd);
        int base;
        base = rnd * OPS + POLLS + 1 + NBEAMS;
        for (int b = 0; b < NBEAMS; b++) begin
            exp_thresh[b] = next_thresh(exp_thresh[b], count_for(rnd, b));
            match_request(base + b, COUNT_BASE + ADDR_W'(b), 1'b1, 32'(exp_thresh[b]));
            match_request(base + NBEAMS + b, ENABLE_BASE + ADDR_W'(b), 1'b1, ENABLE_ON);
        end
        match_request(base + 2 * NBEAMS, CMD_ADDR, 1'b1, CMD_UPDATE);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h91926932));
        reset_i  <= 1'b1;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        wb_adr_i <= '0;
        wb_dat_i <= '0;
        foreach (exp_thresh[b])
            exp_thresh[b] = thresh_t'(RESET_THRESH);
        repeat (4) @(posedge wb_clk_i);
        reset_i <= 1'b0;
        begin : run_tests
            waited = 0;
            while (trig_cyc_o !== 1'b1 && waited < LIMIT) begin
                @(negedge wb_clk_i);
                waited = waited + 1;
            end
            if (trig_cyc_o !== 1'b1) begin
                $display("Timeout: no trigger request within %0d cycles", LIMIT);
                timed_out = 1'b1;
                disable run_tests;
            end
            require(waited >= BOOT, "trigger request during the boot delay");
            compare("trig_adr_o", 32'(CMD_ADDR), 32'(trig_adr_o));
            compare("trig_we_o", 32'd1, 32'(trig_we_o));
            compare("trig_dat_o", CMD_START, trig_dat_o);
            report_test("boot delay and start");
            // First round still running and nothing committed yet
            for (int b = 0; b < NBEAMS; b++)
                read_expect("wb_dat_o threshold", ADDR_W'((1 << REG_SEL_THRESH_BIT) + b),
                            32'(RESET_THRESH));
            read_expect("wb_dat_o gain", '0, 32'(KP));
            if (timed_out)
                disable run_tests;
            report_test("reset values upstream");
            wait_log(OPS);
            if (timed_out)
                disable run_tests;
            check_reads(0);
            report_test("polls before count reads");
            check_writes(0);
            for (int b = 0; b < NBEAMS; b++) begin
                read_expect("wb_dat_o threshold", ADDR_W'((1 << REG_SEL_THRESH_BIT) + b),
                            32'(exp_thresh[b]));
                read_expect("wb_dat_o count", ADDR_W'((1 << REG_SEL_COUNT_BIT) + b),
                            32'(count_for(0, b)));
            end
            if (timed_out)
                disable run_tests;
            report_test("threshold writes and commit");
            wait_log(2 * OPS);
            if (timed_out)
                disable run_tests;
            check_reads(1);
            check_writes(1);                          // Beam 1 now inside the band
            report_test("second round");
            require(stalls > 0, "responder never withheld ack, hold check not reached");
            report_test("back-pressure");
        end
        $display("Tests run %0d, tests failed %0d, failed checks %0d", test_num - 1, failed,
                 total);
        if (timed_out || total != 0) begin
            $display("TB FAILED");
        end else begin
            $display("TB PASSED");
        end
        $finish;
    end

endmodule

//--- threshold_servo_properties.sv
module threshold_servo_properties (
    input  logic                          wb_clk_i,
    input  logic                          reset_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_ack_o,
    input  logic                          trig_cyc_o,
    input  logic                          trig_stb_o,
    input  logic                          trig_we_o,
    input  logic [servo_pkg::ADDR_W-1:0]  trig_adr_o,
    input  logic [servo_pkg::DATA_W-1:0]  trig_dat_o,
    input  logic                          trig_ack_i
);

    //////////////////////////////////////////////////
    // Upstream slave timing
    //////////////////////////////////////////////////
    ack_not_early: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        $rose(wb_cyc_i && wb_stb_i) |=> !wb_ack_o)   // Still busy one cycle on
        else $error("wb_ack_o came one cycle after the request");

    ack_delay: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        $rose(wb_cyc_i && wb_stb_i) |-> ##2 wb_ack_o)
        else $error("wb_ack_o missing two cycles after the request");

    ack_single: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o)                      // Exactly one cycle wide
        else $error("wb_ack_o held longer than one cycle");

    //////////////////////////////////////////////////
    // Trigger master
    //////////////////////////////////////////////////
    reset_quiet: assert property (@(posedge wb_clk_i)
        reset_i |=> !trig_cyc_o && !trig_stb_o && !wb_ack_o)
        else $error("bus active right after reset");

    // Back-pressure must not disturb the held request
    request_hold: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        trig_cyc_o && !trig_ack_i |=> trig_cyc_o && trig_stb_o && $stable(trig_we_o)
            && $stable(trig_adr_o) && $stable(trig_dat_o))
        else $error("trigger request changed while ack was low");

endmodule

bind threshold_servo_top threshold_servo_properties threshold_servo_properties_i (
    .wb_clk_i(wb_clk_i), .reset_i(reset_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_ack_o(wb_ack_o),
    .trig_cyc_o(trig_cyc_o), .trig_stb_o(trig_stb_o), .trig_we_o(trig_we_o),
    .trig_adr_o(trig_adr_o), .trig_dat_o(trig_dat_o), .trig_ack_i(trig_ack_i));

//--- threshold_servo_top.sv
module threshold_servo_top #(
    parameter int NBEAMS            = 2,
    parameter int STARTING_TARGET   = 100,
    parameter int STARTING_KP       = 1,
    parameter int COUNT_MARGIN      = 10,
    parameter int BOOT_DELAY_CLOCKS = 31
) (
    input  logic                          wb_clk_i,
    input  logic                          reset_i,
    // Upstream slave
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [servo_pkg::ADDR_W-1:0]  wb_adr_i,
    input  logic [servo_pkg::DATA_W-1:0]  wb_dat_i,
    output logic                          wb_ack_o,
    output logic [servo_pkg::DATA_W-1:0]  wb_dat_o,
    // Trigger master
    output logic                          trig_cyc_o,
    output logic                          trig_stb_o,
    output logic                          trig_we_o,
    output logic [servo_pkg::ADDR_W-1:0]  trig_adr_o,
    output logic [servo_pkg::DATA_W-1:0]  trig_dat_o,
    input  logic                          trig_ack_i,
    input  logic [servo_pkg::DATA_W-1:0]  trig_dat_i
);

    import servo_pkg::*;
    import trig_bus_pkg::*;

    localparam int IDX_W = $clog2(NBEAMS + 1);

    logic                       boot_start, boot_done;
    logic                       beam_clear, beam_step, last_beam;
    logic [IDX_W-1:0]           beam_idx;
    logic                       issue, req_we, req_sel, bus_done;
    logic [ADDR_W-1:0]          req_adr;
    logic [DATA_W-1:0]          req_dat;
    logic [DATA_W-1:0]          bus_dat;    // Data actually sent
    trig_word_u                 rdata;
    logic                       capture, calc, commit;
    thresh_t                    new_thresh;
    count_t  [NBEAMS-1:0]       counts;
    thresh_t [NBEAMS-1:0]       thresholds;

    // Threshold writes carry the bank value, everything else a constant
    assign bus_dat = req_sel ? DATA_W'(new_thresh) : req_dat;

    loop_timer #(.NBEAMS(NBEAMS), .BOOT_DELAY_CLOCKS(BOOT_DELAY_CLOCKS)) loop_timer_i (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i),
        .boot_start_i(boot_start), .boot_done_o(boot_done),
        .beam_clear_i(beam_clear), .beam_step_i(beam_step),
        .beam_idx_o(beam_idx), .last_beam_o(last_beam));

    servo_fsm #(.NBEAMS(NBEAMS)) servo_fsm_i (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i),
        .boot_done_i(boot_done), .last_beam_i(last_beam), .beam_idx_i(beam_idx),
        .bus_done_i(bus_done), .status_i(rdata), .boot_start_o(boot_start),
        .issue_o(issue), .req_adr_o(req_adr), .req_we_o(req_we),
        .req_dat_o(req_dat), .req_sel_o(req_sel),
        .beam_clear_o(beam_clear), .beam_step_o(beam_step),
        .capture_o(capture), .calc_o(calc), .commit_o(commit));

    trigger_bus_master trigger_bus_master_i (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i),
        .issue_i(issue), .adr_i(req_adr), .we_i(req_we), .dat_i(bus_dat),
        .done_o(bus_done), .rdata_o(rdata),
        .trig_cyc_o(trig_cyc_o), .trig_stb_o(trig_stb_o), .trig_we_o(trig_we_o),
        .trig_adr_o(trig_adr_o), .trig_dat_o(trig_dat_o),
        .trig_ack_i(trig_ack_i), .trig_dat_i(trig_dat_i));

    threshold_bank #(
        .NBEAMS(NBEAMS), .STARTING_TARGET(STARTING_TARGET),
        .STARTING_KP(STARTING_KP), .COUNT_MARGIN(COUNT_MARGIN)
    ) threshold_bank_i (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i), .beam_idx_i(beam_idx),
        .capture_i(capture), .rdata_i(rdata), .calc_i(calc), .commit_i(commit),
        .new_thresh_o(new_thresh), .counts_o(counts), .thresholds_o(thresholds));

    reg_read_port #(.NBEAMS(NBEAMS), .STARTING_KP(STARTING_KP)) reg_read_port_i (
        .wb_clk_i(wb_clk_i), .reset_i(reset_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
        .counts_i(counts), .thresholds_i(thresholds));

endmodule

//--- reg_read_port.sv
module reg_read_port #(
    parameter int NBEAMS      = 2,
    parameter int STARTING_KP = 1
) (
    input  logic                                  wb_clk_i,
    input  logic                                  reset_i,
    input  logic                                  wb_cyc_i,
    input  logic                                  wb_stb_i,
    input  logic                                  wb_we_i,
    input  logic [servo_pkg::ADDR_W-1:0]          wb_adr_i,
    input  logic [servo_pkg::DATA_W-1:0]          wb_dat_i,   // Accepted, never stored
    output logic                                  wb_ack_o,
    output logic [servo_pkg::DATA_W-1:0]          wb_dat_o,
    input  servo_pkg::count_t  [NBEAMS-1:0]       counts_i,
    input  servo_pkg::thresh_t [NBEAMS-1:0]       thresholds_i
);

    import servo_pkg::*;
    import trig_bus_pkg::*;

    localparam kp_t KP = kp_t'(STARTING_KP);

    port_state_e state_q;
    logic [7:0]  sel_idx;   // Beam picked by the low address byte

    assign sel_idx  = wb_adr_i[7:0];
    assign wb_ack_o = (state_q == ack);   // Two cycles after the request

    //////////////////////////////////////////////////
    // Upstream slave
    //////////////////////////////////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q <= idle;
        end else begin
            case (state_q)
                idle:    if (wb_cyc_i && wb_stb_i) state_q <= wb_we_i ? write : read;
                write:   state_q <= ack;    // Writes have no effect
                read:    state_q <= ack;
                default: state_q <= idle;
            endcase
        end
    end

    // Response word, valid in the ack cycle
    always_ff @(posedge wb_clk_i) begin
        if (state_q == read) begin
            if (wb_adr_i[REG_SEL_COUNT_BIT])
                wb_dat_o <= counts_i[sel_idx];
            else if (wb_adr_i[REG_SEL_THRESH_BIT])
                wb_dat_o <= DATA_W'(thresholds_i[sel_idx]);
            else
                wb_dat_o <= KP;
        end else if (state_q == write) begin
            wb_dat_o <= wb_dat_i;   // Echo only, nothing is stored
        end
    end

endmodule

//--- threshold_bank.sv
module threshold_bank #(
    parameter int NBEAMS          = 2,
    parameter int STARTING_TARGET = 100,
    parameter int STARTING_KP     = 1,
    parameter int COUNT_MARGIN    = 10
) (
    input  logic                                  wb_clk_i,
    input  logic                                  reset_i,
    input  logic [$clog2(NBEAMS+1)-1:0]           beam_idx_i,
    input  logic                                  capture_i,  // Store count of current beam
    input  trig_bus_pkg::trig_word_u              rdata_i,
    input  logic                                  calc_i,     // Recalculate current beam
    input  logic                                  commit_i,   // Apply all new thresholds
    output servo_pkg::thresh_t                    new_thresh_o,
    output servo_pkg::count_t  [NBEAMS-1:0]       counts_o,
    output servo_pkg::thresh_t [NBEAMS-1:0]       thresholds_o
);

    import servo_pkg::*;

    // Band around the target rate
    localparam count_t UPPER = count_t'(STARTING_TARGET + COUNT_MARGIN);
    localparam count_t LOWER = count_t'(STARTING_TARGET - COUNT_MARGIN);
    localparam kp_t    KP    = kp_t'(STARTING_KP);

    thresh_t [NBEAMS-1:0] recalc_q;   // Pending thresholds
    count_t               cur_count;
    thresh_t              cur_thresh;

    assign cur_count    = counts_o[beam_idx_i];
    assign cur_thresh   = thresholds_o[beam_idx_i];
    assign new_thresh_o = recalc_q[beam_idx_i];    // Data for the threshold write

    always_ff @(posedge wb_clk_i) begin
        if (capture_i)
            counts_o[beam_idx_i] <= rdata_i.count;
        if (calc_i) begin
            if (cur_count > UPPER)
                recalc_q[beam_idx_i] <= thresh_t'(cur_thresh + KP);  // Too many, raise
            else if (cur_count < LOWER)
                recalc_q[beam_idx_i] <= thresh_t'(cur_thresh - KP);  // Too few, lower
            else
                recalc_q[beam_idx_i] <= cur_thresh;                  // In band
        end
    end

    // Live thresholds change only on the update command
    always_ff @(posedge wb_clk_i) begin
        if (reset_i)
            thresholds_o <= {NBEAMS{START_THRESH}};
        else if (commit_i)
            thresholds_o <= recalc_q;
    end

endmodule

//--- trigger_bus_master.sv
module trigger_bus_master (
    input  logic                          wb_clk_i,
    input  logic                          reset_i,
    input  logic                          issue_i,   // New request, ignored while busy
    input  logic [servo_pkg::ADDR_W-1:0]  adr_i,
    input  logic                          we_i,
    input  logic [servo_pkg::DATA_W-1:0]  dat_i,
    output logic                          done_o,    // One cycle after the ack
    output trig_bus_pkg::trig_word_u      rdata_o,
    output logic                          trig_cyc_o,
    output logic                          trig_stb_o,
    output logic                          trig_we_o,
    output logic [servo_pkg::ADDR_W-1:0]  trig_adr_o,
    output logic [servo_pkg::DATA_W-1:0]  trig_dat_o,
    input  logic                          trig_ack_i,
    input  logic [servo_pkg::DATA_W-1:0]  trig_dat_i
);

    logic req_q;    // Request on the bus
    logic accept;   // Take a new request this cycle
    logic finish;   // Slave acked the held request

    assign accept = issue_i && !req_q;
    assign finish = req_q && trig_ack_i;

    // Control
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            req_q  <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= finish;
            if (accept)
                req_q <= 1'b1;
            else if (finish)
                req_q <= 1'b0;           // Drop on the edge after ack
        end
    end

    // Request payload and reply, held stable through back-pressure
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            trig_adr_o <= adr_i;
            trig_we_o  <= we_i;
            trig_dat_o <= dat_i;
        end
        if (finish)
            rdata_o <= trig_dat_i;       // Valid while done_o is high
    end

    assign trig_cyc_o = req_q;
    assign trig_stb_o = req_q;  // Single transfer per cycle

endmodule

//--- servo_fsm.sv
module servo_fsm #(
    parameter int NBEAMS = 2
) (
    input  logic                            wb_clk_i,
    input  logic                            reset_i,
    input  logic                            boot_done_i,
    input  logic                            last_beam_i,
    input  logic [$clog2(NBEAMS+1)-1:0]     beam_idx_i,
    input  logic                            bus_done_i,  // Trigger operation finished
    input  trig_bus_pkg::trig_word_u        status_i,    // Reply of that operation
    output logic                            boot_start_o,
    output logic                            issue_o,     // Launch one bus operation
    output logic [servo_pkg::ADDR_W-1:0]    req_adr_o,
    output logic                            req_we_o,
    output logic [servo_pkg::DATA_W-1:0]    req_dat_o,   // Command constant
    output logic                            req_sel_o,   // Send threshold instead
    output logic                            beam_clear_o,
    output logic                            beam_step_o,
    output logic                            capture_o,
    output logic                            calc_o,
    output logic                            commit_o
);

    import servo_pkg::*;
    import trig_bus_pkg::*;

    loop_state_e state_q;
    logic        busy_q;    // Operation in flight, wait for done
    logic        per_beam;  // State walks the beams over the bus
    logic        bus_state; // State needs a bus operation now

    always_comb begin
        per_beam  = state_q inside {reading, writing, applying};
        bus_state = (state_q inside {polling, waiting, updating}) || (per_beam && !last_beam_i);
    end

    assign issue_o      = bus_state && !busy_q;    // One issue per step
    assign boot_start_o = (state_q == boot_delay);

    // Request decode, held by the master once issued
    always_comb begin
        req_adr_o = CMD_ADDR;
        req_we_o  = 1'b1;
        req_dat_o = CMD_START;
        req_sel_o = 1'b0;
        case (state_q)
            waiting:  req_we_o = 1'b0;                 // Status poll
            reading: begin
                req_adr_o = COUNT_BASE + beam_idx_i;
                req_we_o  = 1'b0;
            end
            writing: begin
                req_adr_o = COUNT_BASE + beam_idx_i;
                req_sel_o = 1'b1;                      // New threshold as data
            end
            applying: begin
                req_adr_o = ENABLE_BASE + beam_idx_i;
                req_dat_o = ENABLE_ON;
            end
            updating: req_dat_o = CMD_UPDATE;
            default:  ;
        endcase
    end

    // Strobes into the timer and the threshold bank
    assign capture_o    = (state_q == reading) && bus_done_i;
    assign calc_o       = (state_q == calculating) && !last_beam_i;
    assign commit_o     = (state_q == updating) && bus_done_i;
    assign beam_step_o  = (per_beam && bus_done_i) || calc_o;
    assign beam_clear_o = ((state_q == waiting) && bus_done_i && status_i.status.done)
                        || ((per_beam || state_q == calculating) && last_beam_i);

    //////////////////////////////////////////////////
    // Loop sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q <= boot_delay;
            busy_q  <= 1'b0;
        end else begin
            if (issue_o)
                busy_q <= 1'b1;
            else if (bus_done_i)
                busy_q <= 1'b0;
            case (state_q)
                boot_delay:  if (boot_done_i) state_q <= polling;
                polling:     if (bus_done_i) state_q <= waiting;
                waiting:     if (bus_done_i && status_i.status.done) state_q <= reading;
                reading:     if (last_beam_i) state_q <= calculating;
                calculating: if (last_beam_i) state_q <= writing;
                writing:     if (last_beam_i) state_q <= applying;
                applying:    if (last_beam_i) state_q <= updating;
                updating:    if (bus_done_i) state_q <= polling; // Next period
                default:     state_q <= boot_delay;
            endcase
        end
    end

endmodule

//--- loop_timer.sv
module loop_timer #(
    parameter int NBEAMS            = 2,
    parameter int BOOT_DELAY_CLOCKS = 31
) (
    input  logic                          wb_clk_i,
    input  logic                          reset_i,
    input  logic                          boot_start_i, // Count down while high
    output logic                          boot_done_o,
    input  logic                          beam_clear_i,
    input  logic                          beam_step_i,
    output logic [$clog2(NBEAMS+1)-1:0]   beam_idx_o,
    output logic                          last_beam_o   // Index ran past the last beam
);

    localparam int IDX_W  = $clog2(NBEAMS + 1);           // Room for NBEAMS itself
    localparam int BOOT_W = $clog2(BOOT_DELAY_CLOCKS + 1);

    logic [BOOT_W-1:0] boot_cnt_q;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            boot_cnt_q <= BOOT_W'(BOOT_DELAY_CLOCKS); // Reload on every reset
            beam_idx_o <= '0;
        end else begin
            if (boot_start_i && boot_cnt_q != '0)
                boot_cnt_q <= boot_cnt_q - 1'b1;
            // Clear wins over step
            if (beam_clear_i)
                beam_idx_o <= '0;
            else if (beam_step_i)
                beam_idx_o <= beam_idx_o + 1'b1;
        end
    end

    assign boot_done_o = (boot_cnt_q == '0);
    assign last_beam_o = (beam_idx_o == IDX_W'(NBEAMS));

endmodule

//--- trig_bus_pkg.sv
package trig_bus_pkg;

    //////////////////////////////////////////////////
    // Trigger register map
    //////////////////////////////////////////////////
    localparam logic [servo_pkg::ADDR_W-1:0] CMD_ADDR    = 22'h000; // Command and status
    localparam logic [servo_pkg::ADDR_W-1:0] COUNT_BASE  = 22'h100; // Count read, threshold write
    localparam logic [servo_pkg::ADDR_W-1:0] ENABLE_BASE = 22'h200; // Per-beam threshold enable

    // Command and enable codes
    localparam logic [servo_pkg::DATA_W-1:0] CMD_START  = 32'd1; // Begin a counting period
    localparam logic [servo_pkg::DATA_W-1:0] CMD_UPDATE = 32'd2; // Apply all thresholds
    localparam logic [servo_pkg::DATA_W-1:0] ENABLE_ON  = 32'd1;

    // A trigger reply is a status word on a poll and a count on a beam read
    typedef union packed {
        struct packed {
            logic [30:0] reserved;    // Not defined by the trigger
            logic        done;        // Counting period finished
        } status;
        servo_pkg::count_t count;     // Full count of one beam
    } trig_word_u;

    // Upstream address decode
    localparam int REG_SEL_COUNT_BIT  = 8;  // Return a beam count
    localparam int REG_SEL_THRESH_BIT = 9;  // Return a beam threshold

endpackage

//--- servo_pkg.sv
package servo_pkg;

    //////////////////////////////////////////////////
    // Control-loop widths
    //////////////////////////////////////////////////
    localparam int THRESH_W = 18;          // Beam threshold width
    localparam int DATA_W   = 32;          // Bus data width
    localparam int ADDR_W   = 22;          // Bus address width

    typedef logic [THRESH_W-1:0] thresh_t; // One beam threshold
    typedef logic [DATA_W-1:0]   count_t;  // Trigger count over one period
    typedef logic [31:0]         kp_t;     // Loop gain, whole units for now

    // Every threshold restarts here
    localparam thresh_t START_THRESH = 18'd19000;

    //////////////////////////////////////////////////
    // State encodings
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        boot_delay,   // Wait for the trigger to come up
        polling,      // Start a counting period
        waiting,      // Poll until the period is done
        reading,      // Fetch one count per beam
        calculating,  // Nudge thresholds, one beam per cycle
        writing,      // Send new thresholds
        applying,     // Enable each beam's threshold
        updating      // Commit all thresholds at once
    } loop_state_e;

    typedef enum logic [1:0] {
        idle,
        write,        // Upstream write, dropped
        read,         // Load the response word
        ack
    } port_state_e;

endpackage
